// File: Makefile
# Verilator build and run for the FPU control sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_fpc_control
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/fpc_control_top.sv
// FPU control sequencer top
// start capture, strobe generation, state sequencer and LP counter

`include "fpc_defs.svh"

module fpc_control_top (
	input  logic                 got_fp,
	input  logic                 _0_f,
	input  logic                 efp,
	input  fpc_pkg::fpc_op_e     op,
	input  logic [`FPC_LP_W-1:0] words,
	input  logic                 nrf,
	input  logic                 align_eq,
	input  logic                 norm_ok,
	input  logic                 zero,
	input  logic                 di,
	output fpc_pkg::fpc_state_e  state,
	output logic                 busy,
	output logic                 strob1,
	output logic                 strob2,
	output logic                 read_fp,
	output logic                 write_fp,
	output logic                 shift_t,
	output logic                 clock_m,
	output logic [`FPC_LP_W-1:0] lp,
	output logic                 ekc_fp
);

	logic start, norm_only, long_state;
	logic lp_load, lp_step, lp_last;
	fpc_pkg::fpc_op_e job_op;
	logic [`FPC_LP_W-1:0] job_words;

	fpc_start start_i (
		.got_fp(got_fp), ._0_f(_0_f), .efp(efp), .busy(busy),
		.op(op), .words(words), .nrf(nrf),
		.start(start), .norm_only(norm_only),
		.job_op(job_op), .job_words(job_words)
	);

	fpc_strobe_gen strobe_i (
		.got_fp(got_fp), ._0_f(_0_f), .start(start), .busy(busy),
		.long_state(long_state), .strob1(strob1), .strob2(strob2)
	);

	// sequencer paced by strob2, fed back the LP status
	fpc_sequencer seq_i (
		.got_fp(got_fp), ._0_f(_0_f), .start(start), .norm_only(norm_only),
		.job_op(job_op), .strob1(strob1), .strob2(strob2), .lp_last(lp_last),
		.align_eq(align_eq), .norm_ok(norm_ok), .zero(zero), .di(di),
		.state(state), .busy(busy), .long_state(long_state),
		.lp_load(lp_load), .lp_step(lp_step),
		.read_fp(read_fp), .write_fp(write_fp), .shift_t(shift_t),
		.clock_m(clock_m), .ekc_fp(ekc_fp)
	);

	fpc_loop_counter lp_i (
		.got_fp(got_fp), ._0_f(_0_f), .lp_load(lp_load), .lp_step(lp_step),
		.job_words(job_words), .lp(lp), .lp_last(lp_last)
	);

endmodule

// File: rtl/fpc_defs.svh
// FPU control sequencer shared constants
// counter width, strobe delays and mantissa step count

`ifndef FPC_DEFS_SVH
`define FPC_DEFS_SVH

// ----------------------------------------------------------------------
// word counter
// ----------------------------------------------------------------------

// LP counter walks up to three operand words
`define FPC_LP_W 2

// ----------------------------------------------------------------------
// strobe pacing and iteration
// ----------------------------------------------------------------------

// cycles from strob1 to strob2
`define FPC_DLY_SHORT 2
`define FPC_DLY_LONG 4

// mantissa steps for multiply and divide
`define FPC_ITER_STEPS 6

`endif

// File: rtl/fpc_loop_counter.sv
// LP word counter
// loads the word count minus one, counts down per word, flags zero

`include "fpc_defs.svh"

module fpc_loop_counter (
	input  logic                 got_fp,
	input  logic                 _0_f,
	input  logic                 lp_load,
	input  logic                 lp_step,
	input  logic [`FPC_LP_W-1:0] job_words,
	output logic [`FPC_LP_W-1:0] lp,
	output logic                 lp_last
);

	logic [`FPC_LP_W-1:0] lp_init;

	assign lp_init = job_words - {{(`FPC_LP_W-1){1'b0}}, 1'b1};

	// load wins over step
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			lp <= '0;
		end else if (lp_load) begin
			lp <= lp_init;
		end else if (lp_step && !lp_last) begin
			lp <= lp - 1'b1;
		end
	end

	// last word reached, counter holds here
	assign lp_last = (lp == '0);

	a_no_step_at_zero: assert property (@(posedge got_fp) disable iff (_0_f)
		lp_step |-> lp != '0)
		else $error("LP step at zero");

endmodule

// File: rtl/fpc_pkg.sv
// FPU control sequencer types
// operation codes and sequencer state encoding

package fpc_pkg;

	// operation carried by a job
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2,
		OP_DIV = 2'd3
	} fpc_op_e;

	// ------------------------------------------------------------------
	// sequencer states, in job order
	// ------------------------------------------------------------------

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_LOAD  = 3'd1,
		ST_ALIGN = 3'd2,
		ST_ITER  = 3'd3,
		ST_NORM  = 3'd4,
		ST_STORE = 3'd5,
		ST_END   = 3'd6
	} fpc_state_e;

endpackage

// File: rtl/fpc_sequencer.sv
// FPU job state sequencer
// steps load, align, iterate, normalize, store and end on strob2
// and decodes the control pulses from the state and strob1

`include "fpc_defs.svh"

module fpc_sequencer (
	input  logic                got_fp,
	input  logic                _0_f,
	input  logic                start,
	input  logic                norm_only,
	input  fpc_pkg::fpc_op_e    job_op,
	input  logic                strob1,
	input  logic                strob2,
	input  logic                lp_last,
	input  logic                align_eq,
	input  logic                norm_ok,
	input  logic                zero,
	input  logic                di,
	output fpc_pkg::fpc_state_e state,
	output logic                busy,
	output logic                long_state,
	output logic                lp_load,
	output logic                lp_step,
	output logic                read_fp,
	output logic                write_fp,
	output logic                shift_t,
	output logic                clock_m,
	output logic                ekc_fp
);

	localparam int ITER_W = $clog2(`FPC_ITER_STEPS);
	localparam logic [ITER_W-1:0] ITER_LAST = ITER_W'(`FPC_ITER_STEPS - 1);

	fpc_pkg::fpc_state_e state_d;
	logic [ITER_W-1:0] iter_q, iter_d;
	logic norm_done;

	assign norm_done = norm_ok | zero;

	// ------------------------------------------------------------------
	// next state, taken at strob2
	// ------------------------------------------------------------------

	always_comb begin
		state_d = state;
		iter_d  = iter_q;
		if (state == fpc_pkg::ST_IDLE) begin
			if (start)
				state_d = fpc_pkg::ST_LOAD;
		end else if (strob2) begin
			if (di && state != fpc_pkg::ST_END) begin
				// abort
				state_d = fpc_pkg::ST_END;
			end else begin
				case (state)
					fpc_pkg::ST_LOAD: begin
						if (lp_last) begin
							if (norm_only) begin
								state_d = fpc_pkg::ST_NORM;
							end else if (job_op == fpc_pkg::OP_ADD ||
									job_op == fpc_pkg::OP_SUB) begin
								state_d = fpc_pkg::ST_ALIGN;
							end else begin
								state_d = fpc_pkg::ST_ITER;
								iter_d  = '0;
							end
						end
					end
					fpc_pkg::ST_ALIGN: if (align_eq) state_d = fpc_pkg::ST_NORM;
					fpc_pkg::ST_ITER: begin
						if (iter_q == ITER_LAST)
							state_d = fpc_pkg::ST_NORM;
						else
							iter_d = iter_q + 1'b1;
					end
					fpc_pkg::ST_NORM: if (norm_done) state_d = fpc_pkg::ST_STORE;
					fpc_pkg::ST_STORE: if (lp_last) state_d = fpc_pkg::ST_END;
					default: state_d = fpc_pkg::ST_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			state  <= fpc_pkg::ST_IDLE;
			iter_q <= '0;
		end else begin
			state  <= state_d;
			iter_q <= iter_d;
		end
	end

	// ------------------------------------------------------------------
	// status and decoded strobes
	// ------------------------------------------------------------------

	assign busy = (state != fpc_pkg::ST_IDLE);
	assign long_state = (state == fpc_pkg::ST_LOAD) || (state == fpc_pkg::ST_STORE) ||
		(state == fpc_pkg::ST_ITER);

	// counter reload at job start and again for the store pass
	assign lp_load = start || (strob2 && state == fpc_pkg::ST_NORM && norm_done);
	assign lp_step = strob2 && !lp_last &&
		(state == fpc_pkg::ST_LOAD || state == fpc_pkg::ST_STORE);

	assign read_fp  = strob1 && (state == fpc_pkg::ST_LOAD);
	assign write_fp = strob1 && (state == fpc_pkg::ST_STORE);
	assign shift_t  = strob1 && (state == fpc_pkg::ST_ALIGN || state == fpc_pkg::ST_NORM);
	assign clock_m  = strob1 && (state == fpc_pkg::ST_ITER);
	assign ekc_fp   = strob1 && (state == fpc_pkg::ST_END);

	a_strobe_busy: assert property (@(posedge got_fp) disable iff (_0_f)
		(strob1 || strob2) |-> busy)
		else $error("strobe outside a job");

endmodule

// File: rtl/fpc_start.sv
// job start capture
// synchronizes efp, detects its rising edge and latches the job fields

`include "fpc_defs.svh"

module fpc_start (
	input  logic                  got_fp,
	input  logic                  _0_f,
	input  logic                  efp,
	input  logic                  busy,
	input  fpc_pkg::fpc_op_e      op,
	input  logic [`FPC_LP_W-1:0]  words,
	input  logic                  nrf,
	output logic                  start,
	output logic                  norm_only,
	output fpc_pkg::fpc_op_e      job_op,
	output logic [`FPC_LP_W-1:0]  job_words
);

	logic efp_s1, efp_s2, efp_s3;
	fpc_pkg::fpc_op_e op_q;
	logic [`FPC_LP_W-1:0] words_q;
	logic nrf_q;

	// two-flop sync, third flop for the edge
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			efp_s1 <= 1'b0;
			efp_s2 <= 1'b0;
			efp_s3 <= 1'b0;
		end else begin
			efp_s1 <= efp;
			efp_s2 <= efp_s1;
			efp_s3 <= efp_s2;
		end
	end

	// a request while a job runs is dropped
	assign start = efp_s2 & ~efp_s3 & ~busy;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			op_q    <= fpc_pkg::OP_ADD;
			words_q <= '0;
			nrf_q   <= 1'b0;
		end else if (start) begin
			op_q    <= op;
			words_q <= words;
			nrf_q   <= nrf;
		end
	end

	// fields valid in the start cycle already, then held
	assign job_op    = start ? op : op_q;
	assign job_words = start ? words : words_q;
	assign norm_only = start ? nrf : nrf_q;

	a_start_busy: assert property (@(posedge got_fp) disable iff (_0_f)
		start |=> busy && !start)
		else $error("start not followed by busy");

endmodule

// File: rtl/fpc_strobe_gen.sv
// two-phase strobe generator
// strob1 opens a state, strob2 follows after a short or long delay
// and the pair rearms while the sequencer stays busy

`include "fpc_defs.svh"

module fpc_strobe_gen (
	input  logic got_fp,
	input  logic _0_f,
	input  logic start,
	input  logic busy,
	input  logic long_state,
	output logic strob1,
	output logic strob2
);

	localparam int CNT_W = $clog2(`FPC_DLY_LONG + 1);
	localparam logic [CNT_W-1:0] DLY_S = CNT_W'(`FPC_DLY_SHORT - 1);
	localparam logic [CNT_W-1:0] DLY_L = CNT_W'(`FPC_DLY_LONG - 1);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_RUN,
		PH_GAP,
		PH_REARM
	} phase_e;

	phase_e phase;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] dly_last;

	// memory and iteration states run slow
	assign dly_last = long_state ? DLY_L : DLY_S;

	// ------------------------------------------------------------------
	// phase counter
	// ------------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			phase  <= PH_IDLE;
			cnt    <= '0;
			strob1 <= 1'b0;
			strob2 <= 1'b0;
		end else begin
			strob1 <= 1'b0;
			strob2 <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (start) begin
						strob1 <= 1'b1;
						cnt    <= '0;
						phase  <= PH_RUN;
					end
				end
				PH_RUN: begin
					if (cnt == dly_last) begin
						strob2 <= 1'b1;
						phase  <= PH_GAP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				// strob2 cycle, state moves at its end
				PH_GAP: phase <= PH_REARM;
				// new state visible here
				PH_REARM: begin
					if (busy || start) begin
						strob1 <= 1'b1;
						cnt    <= '0;
						phase  <= PH_RUN;
					end else begin
						phase <= PH_IDLE;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// strob2 trails strob1 by the delay of the state class
	a_strobe_short: assert property (@(posedge got_fp) disable iff (_0_f)
		(strob1 && !long_state) |-> ##(`FPC_DLY_SHORT) strob2)
		else $error("strob2 late or missing in a short state");

	a_strobe_long: assert property (@(posedge got_fp) disable iff (_0_f)
		(strob1 && long_state) |-> ##(`FPC_DLY_LONG) strob2)
		else $error("strob2 late or missing in a long state");

endmodule

// File: verification/fpc_stim.txt
# one job per line, decimal fields, op 0 add 1 sub 2 mul 3 div
# op words nrf align_n norm_n zero di then expected read_fp write_fp shift_t clock_m
0 1 0 0 0 0 0 1 1 2 0
0 3 0 2 1 0 0 3 3 5 0
1 2 0 1 3 0 0 2 2 6 0
1 3 0 0 2 1 0 3 3 2 0
2 1 0 0 0 0 0 1 1 1 6
2 3 0 0 2 0 0 3 3 3 6
3 2 0 0 1 0 0 2 2 2 6
3 3 0 0 4 1 0 3 3 1 6
0 2 1 3 2 0 0 2 2 3 0
2 3 1 0 0 1 0 3 3 1 0
3 1 1 0 5 0 0 1 1 6 0
0 3 0 1 0 0 1 1 0 0 0
2 2 0 0 0 0 1 1 0 0 0
1 1 1 0 2 0 1 1 0 0 0
1 1 0 4 0 0 0 1 1 6 0
0 2 0 0 0 1 0 2 2 2 0
2 2 0 0 6 0 0 2 2 7 6
1 3 0 3 3 0 0 3 3 8 0
3 1 0 0 0 1 0 1 1 1 6
0 1 1 0 1 1 0 1 1 1 0

// File: verification/tb_fpc_control.sv
// testbench for the FPU control sequencer
// replays the jobs of the stimulus file and checks the pulse counts per job

`include "fpc_defs.svh"

module tb_fpc_control;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int START_TIMEOUT = 20;
	localparam int JOB_TIMEOUT = 2000;
	localparam int IDLE_CHECK = 12;

	logic got_fp;
	logic _0_f;
	logic efp;
	fpc_pkg::fpc_op_e op;
	logic [`FPC_LP_W-1:0] words;
	logic nrf, align_eq, norm_ok, zero, di;
	fpc_pkg::fpc_state_e state;
	logic busy, strob1, strob2;
	logic read_fp, write_fp, shift_t, clock_m, ekc_fp;
	logic [`FPC_LP_W-1:0] lp;

	// pulse counts of the current job
	logic clr_cnt;
	int n_read, n_write, n_shift, n_clock, n_ekc;
	int n_align_st, align_seen, norm_seen;

	fpc_control_top dut_i (.*);

	initial begin
		got_fp = 1'b0;
		forever #10 got_fp = ~got_fp;
	end

	// counted mid-cycle where all outputs are settled
	always @(negedge got_fp) begin
		if (clr_cnt) begin
			n_read     <= 0;
			n_write    <= 0;
			n_shift    <= 0;
			n_clock    <= 0;
			n_ekc      <= 0;
			n_align_st <= 0;
			align_seen <= 0;
			norm_seen  <= 0;
		end else begin
			n_read     <= n_read + int'(read_fp);
			n_write    <= n_write + int'(write_fp);
			n_shift    <= n_shift + int'(shift_t);
			n_clock    <= n_clock + int'(clock_m);
			n_ekc      <= n_ekc + int'(ekc_fp);
			n_align_st <= n_align_st + int'(state == fpc_pkg::ST_ALIGN);
			align_seen <= align_seen + int'(strob2 && state == fpc_pkg::ST_ALIGN);
			norm_seen  <= norm_seen + int'(strob2 && state == fpc_pkg::ST_NORM);
		end
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		if (got !== exp)
			report_fail($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic wait_job_start();
		int t;
		t = 0;
		@(negedge got_fp);
		while (busy !== 1'b1) begin
			t++;
			if (t > START_TIMEOUT)
				report_fail("timeout, busy never rose after the efp request");
			@(negedge got_fp);
		end
	endtask

	// ------------------------------------------------------------------
	// one job from the stimulus file
	// ------------------------------------------------------------------

	task automatic run_job(input int j_op, input int j_words, input int j_nrf,
		input int j_align, input int j_norm, input int j_zero, input int j_di,
		input int e_read, input int e_write, input int e_shift, input int e_clock);
		int t;
		int gap;
		gap = $urandom_range(8, 1);
		repeat (gap) @(posedge got_fp);
		op       <= fpc_pkg::fpc_op_e'(j_op[1:0]);
		words    <= j_words[`FPC_LP_W-1:0];
		nrf      <= j_nrf[0];
		zero     <= j_zero[0];
		di       <= j_di[0];
		align_eq <= 1'b0;
		norm_ok  <= 1'b0;
		clr_cnt  <= 1'b1;
		efp      <= 1'b1;
		@(posedge got_fp);
		clr_cnt <= 1'b0;
		@(posedge got_fp);
		efp <= 1'b0;
		wait_job_start();
		// second request inside the job, must be dropped
		@(posedge got_fp);
		efp <= 1'b1;
		repeat (2) @(posedge got_fp);
		efp <= 1'b0;
		// datapath conditions follow the strob2 counts
		t = 0;
		do begin
			@(posedge got_fp);
			align_eq <= (align_seen >= j_align);
			norm_ok  <= (norm_seen >= j_norm);
			@(negedge got_fp);
			t++;
			if (t > JOB_TIMEOUT)
				report_fail("timeout, job did not return to idle");
		end while (busy);
		for (int i = 0; i < IDLE_CHECK; i++) begin
			@(negedge got_fp);
			check_val("busy after job", int'(busy), 0);
		end
		check_val("state after job", int'(state), int'(fpc_pkg::ST_IDLE));
		check_val("read_fp count", n_read, e_read);
		check_val("write_fp count", n_write, e_write);
		check_val("shift_t count", n_shift, e_shift);
		check_val("clock_m count", n_clock, e_clock);
		check_val("ekc_fp count", n_ekc, 1);
		if (j_nrf != 0 || j_op >= 2)
			check_val("ALIGN state cycles", n_align_st, 0);
		if (j_di == 0)
			check_val("lp after store", int'(lp), 0);
	endtask

	// ------------------------------------------------------------------
	// reset, then the job list
	// ------------------------------------------------------------------

	initial begin
		int fd;
		int n;
		int jobs;
		string line;
		int f_op, f_words, f_nrf, f_align, f_norm, f_zero, f_di;
		int e_read, e_write, e_shift, e_clock;

		void'($urandom(6064));
		jobs     = 0;
		_0_f     = 1'b1;
		efp      = 1'b0;
		op       = fpc_pkg::OP_ADD;
		words    = '0;
		nrf      = 1'b0;
		align_eq = 1'b0;
		norm_ok  = 1'b0;
		zero     = 1'b0;
		di       = 1'b0;
		clr_cnt  = 1'b1;
		repeat (5) @(posedge got_fp);
		_0_f <= 1'b0;
		@(negedge got_fp);
		check_val("state after reset", int'(state), int'(fpc_pkg::ST_IDLE));
		check_val("busy after reset", int'(busy), 0);
		check_val("strob1 after reset", int'(strob1), 0);
		check_val("strob2 after reset", int'(strob2), 0);
		check_val("ekc_fp after reset", int'(ekc_fp), 0);
		check_val("read_fp after reset", int'(read_fp), 0);
		check_val("write_fp after reset", int'(write_fp), 0);
		check_val("shift_t after reset", int'(shift_t), 0);
		check_val("clock_m after reset", int'(clock_m), 0);

		fd = $fopen("verification/fpc_stim.txt", "r");
		if (fd == 0)
			report_fail("cannot open the stimulus file verification/fpc_stim.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", f_op, f_words, f_nrf,
				f_align, f_norm, f_zero, f_di, e_read, e_write, e_shift, e_clock);
			// comment and blank lines give no fields
			if (n == 11) begin
				run_job(f_op, f_words, f_nrf, f_align, f_norm, f_zero, f_di,
					e_read, e_write, e_shift, e_clock);
				jobs++;
			end else if (n > 0) begin
				report_fail({"malformed stimulus line: ", line});
			end
		end
		$fclose(fd);
		if (jobs == 0) begin
			report_fail("no jobs found in the stimulus file");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: verilog.f
+incdir+rtl
rtl/fpc_pkg.sv
rtl/fpc_start.sv
rtl/fpc_strobe_gen.sv
rtl/fpc_sequencer.sv
rtl/fpc_loop_counter.sv
rtl/fpc_control_top.sv
verification/tb_fpc_control.sv
